/* spartan_consts.svh */
// Bus fabric sizing constants, included by the package and any module that needs raw widths
`ifndef SPARTAN_CONSTS_SVH
`define SPARTAN_CONSTS_SVH

// Width of the request address field
// Only the low part of it selects a register, the rest flags out-of-range
`define SP_ADDR_W 8

// Width of the write and read data words
`define SP_DATA_W 32

// Number of registers implemented in the slave
// Any address at or above this count gets an error response
`define SP_REG_COUNT 16

// Number of masters sharing the fabric
// The source field carried in requests and responses is sized from this
`define SP_MASTERS 2

`endif

/* spartan_pkg.sv */
// Shared request and response types for the fabric, imported by every block that handles them
`include "spartan_consts.svh"

package spartan_pkg;

    // A request as issued by a master and forwarded to the slave
    // Field order sets the bit layout, with write at the top and src at the bottom
    typedef struct packed {
        // High for a write, low for a read
        logic                              write;
        // Register address, values at or above the register count are errors
        logic [`SP_ADDR_W-1:0]             addr;
        // Data to store, ignored for reads
        logic [`SP_DATA_W-1:0]             wdata;
        // Index of the issuing master
        // Masters leave this zero and the arbiter stamps the winner into it
        logic [$clog2(`SP_MASTERS)-1:0]    src;
    } sp_req_t;

    // A response as returned by the slave and routed back to a master
    typedef struct packed {
        // Read data, zero for writes and for errors
        logic [`SP_DATA_W-1:0]             rdata;
        // High when the address was out of range
        logic                              err;
        // Copied from the request so the arbiter can steer the response home
        logic [$clog2(`SP_MASTERS)-1:0]    src;
    } sp_rsp_t;

endpackage

/* spartan_skid.sv */
// Zero-bubble two-entry skid stage on a flat vector, placed at every valid/ready boundary
`timescale 1ns/10ps

module spartan_skid #(
    parameter int WIDTH = 1
) (
    input  logic             CLK,
    input  logic             RST,

    input  logic [WIDTH-1:0] din,
    input  logic             din_val,
    output logic             din_rdy,

    output logic [WIDTH-1:0] dout,
    output logic             dout_val,
    input  logic             dout_rdy
);

    // Side buffer that catches the word arriving while the output is stalled
    logic             skid_val;
    logic [WIDTH-1:0] skid_data;

    // The output register may take a new word when it is empty or being drained
    logic out_load;
    logic in_xfer;

    // Ready comes straight from a register, so the upstream path stays short
    assign din_rdy  = !skid_val;
    assign out_load = !dout_val || dout_rdy;
    assign in_xfer  = din_val && din_rdy;

    // Control state for both entries
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            dout_val <= 1'b0;
            skid_val <= 1'b0;
        end else if (out_load) begin
            // A held word always drains first, and the input is blocked while it is held
            dout_val <= skid_val || din_val;
            skid_val <= 1'b0;
        end else if (in_xfer) begin
            // Output is stalled but the upstream was still told ready last cycle
            skid_val <= 1'b1;
        end
    end

    // Payload registers follow the control above and carry no reset
    always_ff @(posedge CLK) begin
        if (out_load) begin
            dout <= skid_val ? skid_data : din;
        end
        if (!out_load && in_xfer) begin
            skid_data <= din;
        end
    end

    // A stalled word must not change under the receiver
    a_dout_stable: assert property (
        @(posedge CLK) disable iff (RST)
        dout_val && !dout_rdy |=> $stable(dout)
    );

    // A presented word may only leave through a transfer
    a_dout_val_held: assert property (
        @(posedge CLK) disable iff (RST)
        dout_val && !dout_rdy |=> dout_val
    );

endmodule

/* spartan_arb.sv */
// Two-master round-robin request arbiter that also steers responses back by source index
`timescale 1ns/10ps

module spartan_arb import spartan_pkg::*; (
    input  logic    CLK,
    input  logic    RST,

    // Request inputs, one per master
    input  sp_req_t req0,
    input  logic    req0_val,
    output logic    req0_rdy,
    input  sp_req_t req1,
    input  logic    req1_val,
    output logic    req1_rdy,

    // Merged request stream toward the slave
    output sp_req_t req_out,
    output logic    req_out_val,
    input  logic    req_out_rdy,

    // Response stream from the slave
    input  sp_rsp_t rsp_in,
    input  logic    rsp_in_val,
    output logic    rsp_in_rdy,

    // Response outputs, one per master
    output sp_rsp_t rsp0,
    output logic    rsp0_val,
    input  logic    rsp0_rdy,
    output sp_rsp_t rsp1,
    output logic    rsp1_val,
    input  logic    rsp1_rdy
);

    // Current grant, 0 for master 0 and 1 for master 1
    logic gnt;
    // Winner of the most recent transfer, used to alternate on contention
    logic last_gnt;
    // Set while a granted request waits downstream, with the held grant beside it
    logic lock;
    logic lock_gnt;
    logic req_xfer;

    // A locked grant wins over everything, so a late arrival cannot steal a stalled slot
    // Without a lock the other master gets priority when both ask at once
    always_comb begin
        if (lock) begin
            gnt = lock_gnt;
        end else if (req0_val && req1_val) begin
            gnt = ~last_gnt;
        end else begin
            gnt = req1_val;
        end
    end

    // Forward the winner and mark it with its source index
    always_comb begin
        req_out     = gnt ? req1 : req0;
        req_out.src = gnt;
    end

    assign req_out_val = gnt ? req1_val : req0_val;
    assign req_xfer    = req_out_val && req_out_rdy;

    // Only the granted master sees downstream ready
    assign req0_rdy = req_out_rdy && !gnt;
    assign req1_rdy = req_out_rdy && gnt;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            // Start as if master 1 had just won, so master 0 goes first
            last_gnt <= 1'b1;
            lock     <= 1'b0;
            lock_gnt <= 1'b0;
        end else if (req_xfer) begin
            last_gnt <= gnt;
            lock     <= 1'b0;
        end else if (req_out_val) begin
            // Offered but not taken, so pin the grant until it goes through
            lock     <= 1'b1;
            lock_gnt <= gnt;
        end
    end

    // Both outputs carry the same payload and only the valid is steered
    assign rsp0 = rsp_in;
    assign rsp1 = rsp_in;

    assign rsp0_val = rsp_in_val && (rsp_in.src == 1'b0);
    assign rsp1_val = rsp_in_val && (rsp_in.src == 1'b1);

    // Ready comes back only from the port the response is headed to
    assign rsp_in_rdy = (rsp_in.src == 1'b1) ? rsp1_rdy : rsp0_rdy;

    // A master left waiting while the other one transfers wins the next grant
    a_alternate: assert property (
        @(posedge CLK) disable iff (RST)
        req_xfer && (gnt ? req0_val : req1_val) |=> gnt != $past(gnt)
    );

    // The slave side sees a steady request while it stalls, whatever the other master does
    a_grant_held: assert property (
        @(posedge CLK) disable iff (RST)
        req_out_val && !req_out_rdy |=> req_out_val && $stable(req_out)
    );

endmodule

/* spartan_regfile.sv */
// Register-file slave answering each read or write request with one data or error response
`timescale 1ns/10ps
`include "spartan_consts.svh"

module spartan_regfile import spartan_pkg::*; (
    input  logic    CLK,
    input  logic    RST,

    // Incoming request channel
    input  sp_req_t req,
    input  logic    req_val,
    output logic    req_rdy,

    // Outgoing response channel
    output sp_rsp_t rsp,
    output logic    rsp_val,
    input  logic    rsp_rdy
);

    // Bits of the address that select a register
    localparam int IDX_W = $clog2(`SP_REG_COUNT);

    // First address that is out of range, sized to the address field
    localparam logic [`SP_ADDR_W-1:0] ADDR_LIMIT = `SP_ADDR_W'(`SP_REG_COUNT);

    // Register storage
    logic [`SP_DATA_W-1:0] regs [`SP_REG_COUNT];

    logic             req_xfer;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // One response register, so a new request fits only when it is empty or draining
    assign req_rdy  = !rsp_val || rsp_rdy;
    assign req_xfer = req_val && req_rdy;

    assign in_range = req.addr < ADDR_LIMIT;
    assign idx      = req.addr[IDX_W-1:0];

    // Storage clears on reset so reads before any write return zero
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < `SP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (req_xfer && req.write && in_range) begin
            regs[idx] <= req.wdata;
        end
    end

    // Response valid rises one cycle after acceptance
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rsp_val <= 1'b0;
        end else if (req_rdy) begin
            rsp_val <= req_val;
        end
    end

    // Response payload, loaded only on acceptance
    // Reads see the value before any write in the same cycle, which cannot overlap anyway
    always_ff @(posedge CLK) begin
        if (req_xfer) begin
            rsp.src <= req.src;
            rsp.err <= !in_range;
            if (!req.write && in_range) begin
                rsp.rdata <= regs[idx];
            end else begin
                // Writes and errors return zero data
                rsp.rdata <= '0;
            end
        end
    end

    // A stalled response keeps both its valid and its payload
    a_rsp_stable: assert property (
        @(posedge CLK) disable iff (RST)
        rsp_val && !rsp_rdy |=> rsp_val && $stable(rsp)
    );

endmodule

/* spartan_fabric.sv */
// Top level of the two-master fabric, tying skid stages, arbiter and register-file slave together
`timescale 1ns/10ps

module spartan_fabric import spartan_pkg::*; (
    input  logic    CLK,
    input  logic    RST,

    // Master 0 channels
    input  sp_req_t req0,
    input  logic    req0_val,
    output logic    req0_rdy,
    output sp_rsp_t rsp0,
    output logic    rsp0_val,
    input  logic    rsp0_rdy,

    // Master 1 channels
    input  sp_req_t req1,
    input  logic    req1_val,
    output logic    req1_rdy,
    output sp_rsp_t rsp1,
    output logic    rsp1_val,
    input  logic    rsp1_rdy
);

    // Registered master requests feeding the arbiter
    sp_req_t m0_req;
    logic    m0_req_val;
    logic    m0_req_rdy;
    sp_req_t m1_req;
    logic    m1_req_val;
    logic    m1_req_rdy;

    // Merged stream between the arbiter and the slave request stage
    sp_req_t arb_req;
    logic    arb_req_val;
    logic    arb_req_rdy;

    // Registered request at the slave
    sp_req_t rf_req;
    logic    rf_req_val;
    logic    rf_req_rdy;

    // Slave response before and after its skid stage
    sp_rsp_t rf_rsp;
    logic    rf_rsp_val;
    logic    rf_rsp_rdy;
    sp_rsp_t arb_rsp;
    logic    arb_rsp_val;
    logic    arb_rsp_rdy;

    // Each master request enters through its own stage
    spartan_skid #(.WIDTH($bits(sp_req_t))) u_m0_skid (
        .CLK(CLK), .RST(RST),
        .din(req0), .din_val(req0_val), .din_rdy(req0_rdy),
        .dout(m0_req), .dout_val(m0_req_val), .dout_rdy(m0_req_rdy)
    );

    spartan_skid #(.WIDTH($bits(sp_req_t))) u_m1_skid (
        .CLK(CLK), .RST(RST),
        .din(req1), .din_val(req1_val), .din_rdy(req1_rdy),
        .dout(m1_req), .dout_val(m1_req_val), .dout_rdy(m1_req_rdy)
    );

    spartan_arb u_arb (
        .CLK(CLK), .RST(RST),
        .req0(m0_req), .req0_val(m0_req_val), .req0_rdy(m0_req_rdy),
        .req1(m1_req), .req1_val(m1_req_val), .req1_rdy(m1_req_rdy),
        .req_out(arb_req), .req_out_val(arb_req_val), .req_out_rdy(arb_req_rdy),
        .rsp_in(arb_rsp), .rsp_in_val(arb_rsp_val), .rsp_in_rdy(arb_rsp_rdy),
        .rsp0(rsp0), .rsp0_val(rsp0_val), .rsp0_rdy(rsp0_rdy),
        .rsp1(rsp1), .rsp1_val(rsp1_val), .rsp1_rdy(rsp1_rdy)
    );

    // Cuts the combinational arbiter off from the slave
    spartan_skid #(.WIDTH($bits(sp_req_t))) u_req_skid (
        .CLK(CLK), .RST(RST),
        .din(arb_req), .din_val(arb_req_val), .din_rdy(arb_req_rdy),
        .dout(rf_req), .dout_val(rf_req_val), .dout_rdy(rf_req_rdy)
    );

    spartan_regfile u_regfile (
        .CLK(CLK), .RST(RST),
        .req(rf_req), .req_val(rf_req_val), .req_rdy(rf_req_rdy),
        .rsp(rf_rsp), .rsp_val(rf_rsp_val), .rsp_rdy(rf_rsp_rdy)
    );

    // Holds responses while the addressed master is not ready
    spartan_skid #(.WIDTH($bits(sp_rsp_t))) u_rsp_skid (
        .CLK(CLK), .RST(RST),
        .din(rf_rsp), .din_val(rf_rsp_val), .din_rdy(rf_rsp_rdy),
        .dout(arb_rsp), .dout_val(arb_rsp_val), .dout_rdy(arb_rsp_rdy)
    );

endmodule

/* tb_spartan.sv */
// Table-driven testbench for the two-master fabric, run as the simulation top with the RTL
`timescale 1ns/10ps
`include "spartan_consts.svh"

module tb_spartan import spartan_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    // Each master owns one half of the register space
    localparam int HALF = `SP_REG_COUNT / `SP_MASTERS;

    // One transaction with the response the slave rules call for
    typedef struct packed {
        logic    master;
        sp_req_t req;
        sp_rsp_t exp;
    } row_t;

    logic              CLK;
    logic              RST;
    sp_req_t [1:0]     req_drv;
    logic    [1:0]     req_val;
    logic    [1:0]     req_rdy;
    sp_rsp_t [1:0]     rsp_mon;
    logic    [1:0]     rsp_val;
    logic    [1:0]     rsp_rdy;

    row_t              rows [$];
    logic [`SP_DATA_W-1:0] model [`SP_REG_COUNT];
    sp_rsp_t           exp_q0 [$];
    sp_rsp_t           exp_q1 [$];
    int                row_ptr [2];
    logic [1:0]        req_taken;
    logic [15:0]       lfsr;
    logic              table_ready;

    spartan_fabric UUT (
        .CLK(CLK), .RST(RST),
        .req0(req_drv[0]), .req0_val(req_val[0]), .req0_rdy(req_rdy[0]),
        .rsp0(rsp_mon[0]), .rsp0_val(rsp_val[0]), .rsp0_rdy(rsp_rdy[0]),
        .req1(req_drv[1]), .req1_val(req_val[1]), .req1_rdy(req_rdy[1]),
        .rsp1(rsp_mon[1]), .rsp1_val(rsp_val[1]), .rsp1_rdy(rsp_rdy[1])
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped");
    endtask

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_lfsr_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    function automatic logic [`SP_DATA_W-1:0] pattern(input int m, input int a);
        return {4'hC, 4'(m), 8'(a), 8'(~a), 8'h3C};
    endfunction

    // Appends a row and works out its response from the slave rules on the model
    task automatic add_row(input int m, input logic wr, input int addr,
                           input logic [`SP_DATA_W-1:0] wdata);
        row_t r;
        r.master    = 1'(m);
        r.req.write = wr;
        r.req.addr  = `SP_ADDR_W'(addr);
        r.req.wdata = wr ? wdata : '0;
        r.req.src   = '0;
        r.exp.src   = 1'(m);
        if (addr < `SP_REG_COUNT) begin
            r.exp.err = 1'b0;
            if (wr) begin
                model[addr] = wdata;
                r.exp.rdata = '0;
            end else begin
                r.exp.rdata = model[addr];
            end
        end else begin
            r.exp.err   = 1'b1;
            r.exp.rdata = '0;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        int base;
        for (int i = 0; i < `SP_REG_COUNT; i++) begin
            model[i] = '0;
        end
        for (int m = 0; m < `SP_MASTERS; m++) begin
            base = m * HALF;
            // Registers come out of reset as zero
            add_row(m, 1'b0, base, '0);
            for (int i = 0; i < HALF; i++) begin
                add_row(m, 1'b1, base + i, pattern(m, i));
                add_row(m, 1'b0, base + i, '0);
            end
            // Out-of-range traffic, some of it aliasing the master's own low bits
            add_row(m, 1'b1, `SP_REG_COUNT + base, 32'hDEAD_BEEF);
            add_row(m, 1'b0, `SP_REG_COUNT + base + 1, '0);
            add_row(m, 1'b1, 255 - m, 32'hFFFF_FFFF);
            add_row(m, 1'b0, 128 + base, '0);
            // Sweep again to show none of the error writes landed
            for (int i = 0; i < HALF; i++) begin
                add_row(m, 1'b0, base + i, '0);
            end
        end
    endtask

    function automatic int next_row(input int m, input int from);
        int i;
        i = from;
        while (i < rows.size() && rows[i].master != 1'(m)) begin
            i++;
        end
        return i;
    endfunction

    function automatic logic all_done();
        return row_ptr[0] >= rows.size() && row_ptr[1] >= rows.size()
            && exp_q0.size() == 0 && exp_q1.size() == 0;
    endfunction

    // Called on a falling edge; DUT outputs here are what the next rising edge sees
    task automatic step_master(input int m);
        sp_rsp_t exp;
        logic    rdy_bit;
        // A request taken at the last rising edge frees the master for its next row
        if (req_taken[m]) begin
            row_ptr[m] = next_row(m, row_ptr[m] + 1);
        end
        if (row_ptr[m] < rows.size()) begin
            req_drv[m] = rows[row_ptr[m]].req;
            req_val[m] = 1'b1;
        end else begin
            req_drv[m] = '0;
            req_val[m] = 1'b0;
        end
        take_lfsr_bit(rdy_bit);
        rsp_rdy[m] = rdy_bit;
        req_taken[m] = req_val[m] && req_rdy[m];
        if (req_taken[m]) begin
            if (m == 0) begin
                exp_q0.push_back(rows[row_ptr[m]].exp);
            end else begin
                exp_q1.push_back(rows[row_ptr[m]].exp);
            end
        end
        if (rsp_val[m] && rsp_rdy[m]) begin
            if ((m == 0 && exp_q0.size() == 0) || (m == 1 && exp_q1.size() == 0)) begin
                stop_run($sformatf("Master %0d got a response with no request outstanding", m));
            end else begin
                if (m == 0) begin
                    exp = exp_q0.pop_front();
                end else begin
                    exp = exp_q1.pop_front();
                end
                check_value($sformatf("rsp%0d.rdata", m), 64'(rsp_mon[m].rdata),
                            64'(exp.rdata));
                check_value($sformatf("rsp%0d.err", m), 64'(rsp_mon[m].err), 64'(exp.err));
                check_value($sformatf("rsp%0d.src", m), 64'(rsp_mon[m].src), 64'(exp.src));
            end
        end
    endtask

    // Watchdog sized at 40 cycles per table row plus the reset period
    initial begin
        wait (table_ready === 1'b1);
        #(CLK_PERIOD * (40 * rows.size() + 10));
        $display("Timed out with requests or responses still outstanding");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        CLK         = 1'b0;
        RST         = 1'b1;
        req_drv     = '0;
        req_val     = '0;
        rsp_rdy     = '0;
        req_taken   = '0;
        lfsr        = 16'd47;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        // Idle state straight out of reset
        check_value("rsp0_val", 64'(rsp_val[0]), 64'd0);
        check_value("rsp1_val", 64'(rsp_val[1]), 64'd0);
        check_value("req0_rdy", 64'(req_rdy[0]), 64'd1);
        check_value("req1_rdy", 64'(req_rdy[1]), 64'd1);

        row_ptr[0] = next_row(0, 0);
        row_ptr[1] = next_row(1, 0);
        while (!all_done()) begin
            step_master(0);
            step_master(1);
            @(negedge CLK);
        end

        // Nothing more may come back once every request has its response
        req_val = '0;
        rsp_rdy = 2'b11;
        repeat (8) begin
            @(negedge CLK);
            check_value("rsp0_val", 64'(rsp_val[0]), 64'd0);
            check_value("rsp1_val", 64'(rsp_val[1]), 64'd0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
spartan_pkg.sv
spartan_skid.sv
spartan_arb.sv
spartan_regfile.sv
spartan_fabric.sv
tb_spartan.sv

/* Makefile */
# Verilator build and run of the fabric testbench

SRCS := $(shell grep -v '^+' all.f) spartan_consts.svh

.PHONY: run build clean

run: obj_dir/Vtb_spartan
	-./obj_dir/Vtb_spartan > sim.log 2>&1
	cat sim.log
	! grep -qx "Finished with errors" sim.log
	grep -qx "Finished with no errors" sim.log

build: obj_dir/Vtb_spartan

obj_dir/Vtb_spartan: all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_spartan -f all.f

clean:
	rm -rf obj_dir sim.log
